// File: logic/lane_word_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_lane_config.svh"

module lane_word_select
   import tx_lane_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  lane_in_t   i_lane_in,
   tx_ctrl_if.lane    ctrl,
   output lane_word_t o_word
);

   // Word view of the lane input
   lane_word_t [`TX_WORDS-1:0] words;

   assign words = i_lane_in;

   // Zero words go out while the link is unlocked
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_word <= '0;
      end else if (ctrl.capture) begin
         if (ctrl.locked) begin
            o_word <= words[ctrl.sel];
         end else begin
            o_word <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/lvds_tx_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_lane_config.svh"

module lvds_tx_lanes
   import tx_lane_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_pll_areset,
   input  word_sel_t            i_sel,
   input  lane_bus_t            i_par_data,
   output logic [`TX_LANES-1:0] o_tx_out,
   output logic                 o_tx_locked,
   output logic                 o_tx_outclock,
   output logic                 o_tx_frame
);

   tx_ctrl_if ctrl_if ();

   lane_word_t lane_words [`TX_LANES];

   tx_frame_ctrl u_frame_ctrl (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_pll_areset (i_pll_areset),
      .i_sel        (i_sel),
      .o_tx_locked  (o_tx_locked),
      .ctrl         (ctrl_if.ctrl)
   );

   // One word register per lane
   for (genvar k = 0; k < `TX_LANES; k++) begin : g_lane
      lane_word_select u_word_select (
         .i_clk     (i_clk),
         .i_rst_n   (i_rst_n),
         .i_lane_in (i_par_data[k*`TX_IN_W +: `TX_IN_W]),
         .ctrl      (ctrl_if.lane),
         .o_word    (lane_words[k])
      );
   end

   tx_serializer u_serializer (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_words       (lane_words),
      .ctrl          (ctrl_if.ser),
      .o_tx_out      (o_tx_out),
      .o_tx_frame    (o_tx_frame),
      .o_tx_outclock (o_tx_outclock)
   );

endmodule

`default_nettype wire

// File: logic/tx_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tx_ctrl_if
   import tx_lane_pkg::*;
();

   // Link lock level
   logic      locked;

   // Word select, updated once per frame
   word_sel_t sel;

   // Single-cycle strobes, capture at phase 8 and load at phase 9
   logic      capture;
   logic      load;

   modport ctrl (
      output locked,
      output sel,
      output capture,
      output load
   );

   modport lane (
      input locked,
      input sel,
      input capture
   );

   modport ser (
      input load
   );

endinterface

`default_nettype wire

// File: logic/tx_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_lane_config.svh"

module tx_frame_ctrl
   import tx_lane_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_pll_areset,
   input  word_sel_t i_sel,
   output logic      o_tx_locked,
   tx_ctrl_if.ctrl   ctrl
);

   localparam int LOCK_W = $clog2(`TX_LOCK_CYCLES + 1);
   localparam bit_phase_t LAST_PHASE = bit_phase_t'(`TX_WORD_W - 1);

   // Strobes are registered, so decode one phase early
   localparam bit_phase_t PRE_CAPTURE = bit_phase_t'(`TX_WORD_W - 3);
   localparam bit_phase_t PRE_LOAD = bit_phase_t'(`TX_WORD_W - 2);

   logic [LOCK_W-1:0] lock_cnt;
   logic              locked_q;
   bit_phase_t        phase;
   logic              capture_q;
   logic              load_q;
   word_sel_t         sel_q;

   // PLL lock model
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         lock_cnt <= '0;
         locked_q <= 1'b0;
      end else if (i_pll_areset) begin
         lock_cnt <= '0;
         locked_q <= 1'b0;
      end else if (!locked_q) begin
         lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == LOCK_W'(`TX_LOCK_CYCLES - 1)) begin
            locked_q <= 1'b1;
         end
      end
   end

   // Bit phase, free running 0 to 9
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= '0;
      end else if (phase == LAST_PHASE) begin
         phase <= '0;
      end else begin
         phase <= phase + 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         capture_q <= 1'b0;
         load_q    <= 1'b0;
      end else begin
         capture_q <= (phase == PRE_CAPTURE);
         load_q    <= (phase == PRE_LOAD);
      end
   end

   // Select is held stable through the capture cycle
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sel_q <= '0;
      end else if (phase == PRE_CAPTURE) begin
         sel_q <= i_sel;
      end
   end

   assign ctrl.locked  = locked_q;
   assign ctrl.sel     = sel_q;
   assign ctrl.capture = capture_q;
   assign ctrl.load    = load_q;

   assign o_tx_locked = locked_q;

endmodule

`default_nettype wire

// File: logic/tx_lane_config.svh
`ifndef TX_LANE_CONFIG_SVH
`define TX_LANE_CONFIG_SVH

// Number of serial lanes
`define TX_LANES 4

// Parallel input per lane
`define TX_IN_W 40

// Serial word, one bit per clock
`define TX_WORD_W 10

// Words packed in one lane input
`define TX_WORDS 4

// Clocks from reset or PLL reset release until lock
`define TX_LOCK_CYCLES 32

`endif

// File: logic/tx_lane_pkg.sv
`default_nettype none

`include "tx_lane_config.svh"

package tx_lane_pkg;

   // One serial word
   typedef logic [`TX_WORD_W-1:0] lane_word_t;

   // One lane input, word n at bits 10n+9 down to 10n
   typedef logic [`TX_IN_W-1:0] lane_in_t;

   typedef logic [$clog2(`TX_WORDS)-1:0] word_sel_t;

   // Bit position within a frame, 0 to 9
   typedef logic [3:0] bit_phase_t;

   // All lane inputs, lane k in the k-th slice
   typedef logic [`TX_LANES*`TX_IN_W-1:0] lane_bus_t;

endpackage

`default_nettype wire

// File: logic/tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_lane_config.svh"

module tx_serializer
   import tx_lane_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  lane_word_t           i_words [`TX_LANES],
   tx_ctrl_if.ser               ctrl,
   output logic [`TX_LANES-1:0] o_tx_out,
   output logic                 o_tx_frame,
   output logic                 o_tx_outclock
);

   localparam bit_phase_t LAST_POS = bit_phase_t'(`TX_WORD_W - 1);
   localparam bit_phase_t CLK_HIGH_BITS = bit_phase_t'(`TX_WORD_W / 2);

   bit_phase_t pos;
   lane_word_t shreg [`TX_LANES];

   // Frame position, parked at the last bit until the first load
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pos <= LAST_POS;
      end else if (ctrl.load) begin
         pos <= '0;
      end else if (pos != LAST_POS) begin
         pos <= pos + 1'b1;
      end
   end

   for (genvar k = 0; k < `TX_LANES; k++) begin : g_lane
      // MSB first
      always_ff @(posedge i_clk or negedge i_rst_n) begin
         if (!i_rst_n) begin
            shreg[k] <= '0;
         end else if (ctrl.load) begin
            shreg[k] <= i_words[k];
         end else if (pos != LAST_POS) begin
            shreg[k] <= {shreg[k][`TX_WORD_W-2:0], 1'b0};
         end
      end

      assign o_tx_out[k] = shreg[k][`TX_WORD_W-1];
   end

   assign o_tx_frame = (pos == '0);

   // High for the first half of the frame
   assign o_tx_outclock = (pos < CLK_HIGH_BITS);

endmodule

`default_nettype wire

// File: lvds_tx_lanes.f
+incdir+logic
logic/tx_lane_pkg.sv
logic/tx_ctrl_if.sv
logic/tx_frame_ctrl.sv
logic/lane_word_select.sv
logic/tx_serializer.sv
logic/lvds_tx_lanes.sv
testbench/tb_lvds_tx_lanes.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the lvds_tx_lanes testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --timescale 1ns/1ps \
   -f lvds_tx_lanes.f \
   --top-module tb_lvds_tx_lanes \
   --Mdir obj_dir \
   -o tb_lvds_tx_lanes

./obj_dir/tb_lvds_tx_lanes 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation reported failures, see sim.log"
   exit 1
fi

echo "simulation finished without failures"
exit 0

// File: testbench/tb_lvds_tx_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_lane_config.svh"

module tb_lvds_tx_lanes
   import tx_lane_pkg::*;
();

   localparam int N_ROWS = 20;
   localparam int EXP_W = `TX_LANES * `TX_WORD_W;
   localparam int TIMEOUT_CYCLES = (N_ROWS + 4) * 10 + 16 + 2 * `TX_LOCK_CYCLES;

   logic                 i_clk;
   logic                 i_rst_n;
   logic                 i_pll_areset;
   word_sel_t            i_sel;
   lane_bus_t            i_par_data;
   logic [`TX_LANES-1:0] o_tx_out;
   logic                 o_tx_locked;
   logic                 o_tx_outclock;
   logic                 o_tx_frame;

   // Stimulus table
   string     row_name      [N_ROWS];
   word_sel_t row_sel       [N_ROWS];
   logic      row_sel_rand  [N_ROWS];
   logic      row_areset    [N_ROWS];
   logic      row_data_rand [N_ROWS];
   int        n_rows;

   // Expected words with one entry per serialized frame
   string            exp_names [$];
   logic [EXP_W-1:0] exp_words [$];

   int          errors;
   int          timeouts;
   int          cycles;
   int          frames_checked;
   int          lock_wait;
   int          ref_cnt;
   logic        ref_locked;
   logic [15:0] lfsr_q;

   lvds_tx_lanes UUT (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_pll_areset  (i_pll_areset),
      .i_sel         (i_sel),
      .i_par_data    (i_par_data),
      .o_tx_out      (o_tx_out),
      .o_tx_locked   (o_tx_locked),
      .o_tx_outclock (o_tx_outclock),
      .o_tx_frame    (o_tx_frame)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // Lock reference counting clocks since reset or PLL reset release
   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ref_cnt <= 0;
      end else if (i_pll_areset) begin
         ref_cnt <= 0;
      end else if (ref_cnt < `TX_LOCK_CYCLES) begin
         ref_cnt <= ref_cnt + 1;
      end
   end

   assign ref_locked = (ref_cnt >= `TX_LOCK_CYCLES);

   always @(posedge i_clk) begin
      cycles++;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      // x^16 + x^14 + x^13 + x^11 + 1
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic take_bit(output logic b);
      lfsr_q = lfsr_next(lfsr_q);
      b = lfsr_q[0];
   endtask

   task automatic random_bus(output lane_bus_t v);
      logic b;
      for (int i = 0; i < $bits(lane_bus_t); i++) begin
         take_bit(b);
         v[i] = b;
      end
   endtask

   task automatic random_sel(output word_sel_t s);
      logic b;
      for (int i = 0; i < $bits(word_sel_t); i++) begin
         take_bit(b);
         s[i] = b;
      end
   endtask

   // Every slice of every lane differs from all others
   function automatic lane_bus_t fixed_pattern();
      lane_bus_t  v;
      lane_word_t w;
      v = '0;
      for (int k = 0; k < `TX_LANES; k++) begin
         for (int n = 0; n < `TX_WORDS; n++) begin
            w = {2'(n), 2'(k), 6'h2d ^ 6'(k * 4 + n)};
            v[k * `TX_IN_W + n * `TX_WORD_W +: `TX_WORD_W] = w;
         end
      end
      return v;
   endfunction

   // Word n sits at bits 10n+9 down to 10n
   function automatic lane_word_t slice_of(input lane_in_t d, input word_sel_t s);
      int idx;
      idx = int'(s) * `TX_WORD_W;
      return d[idx +: `TX_WORD_W];
   endfunction

   task automatic check_word(input string name, input lane_word_t exp, input lane_word_t act);
      if (act !== exp) begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic add_row(input string name, input word_sel_t sel, input logic sel_rand,
                          input logic areset, input logic data_rand);
      row_name[n_rows]      = name;
      row_sel[n_rows]       = sel;
      row_sel_rand[n_rows]  = sel_rand;
      row_areset[n_rows]    = areset;
      row_data_rand[n_rows] = data_rand;
      n_rows++;
   endtask

   task automatic load_table();
      n_rows = 0;
      // Applied before lock
      add_row("unlocked_0", 2'd0, 1'b0, 1'b0, 1'b0);
      add_row("unlocked_1", 2'd1, 1'b0, 1'b0, 1'b0);
      add_row("fixed_sel0", 2'd0, 1'b0, 1'b0, 1'b0);
      add_row("fixed_sel1", 2'd1, 1'b0, 1'b0, 1'b0);
      add_row("fixed_sel2", 2'd2, 1'b0, 1'b0, 1'b0);
      add_row("fixed_sel3", 2'd3, 1'b0, 1'b0, 1'b0);
      add_row("lfsr_0", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("lfsr_1", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("lfsr_2", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("lfsr_3", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("lfsr_4", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("lfsr_5", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("pll_areset", 2'd2, 1'b0, 1'b1, 1'b0);
      // Lock returns somewhere in here
      add_row("relock_0", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("relock_1", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("relock_2", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("relock_3", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("relock_4", 2'd0, 1'b1, 1'b0, 1'b1);
      add_row("relock_fixed", 2'd3, 1'b0, 1'b0, 1'b0);
      add_row("relock_lfsr", 2'd0, 1'b1, 1'b0, 1'b1);
   endtask

   // Drive one row for a whole frame and queue the word it should produce
   task automatic drive_row(input int r);
      lane_bus_t        bus;
      word_sel_t        sel;
      lane_in_t         lane_in;
      logic [EXP_W-1:0] exp;
      do @(negedge i_clk); while (!o_tx_frame);
      @(posedge i_clk);
      #1;
      if (row_data_rand[r]) begin
         random_bus(bus);
      end else begin
         bus = fixed_pattern();
      end
      if (row_sel_rand[r]) begin
         random_sel(sel);
      end else begin
         sel = row_sel[r];
      end
      i_par_data   = bus;
      i_sel        = sel;
      i_pll_areset = row_areset[r];
      // Lock state as seen by the capture edge
      repeat (7) @(posedge i_clk);
      #1;
      check_bit({row_name[r], " lock"}, ref_locked, o_tx_locked);
      for (int k = 0; k < `TX_LANES; k++) begin
         lane_in = bus[k * `TX_IN_W +: `TX_IN_W];
         exp[k * `TX_WORD_W +: `TX_WORD_W] = ref_locked ? slice_of(lane_in, sel) : '0;
      end
      exp_names.push_back(row_name[r]);
      exp_words.push_back(exp);
   endtask

   // Frames run back to back, so a frame marker must follow every tenth bit
   task automatic collect_frames();
      lane_word_t       got [`TX_LANES];
      string            name;
      logic [EXP_W-1:0] exp;
      logic             have_exp;
      do @(negedge i_clk); while (!o_tx_frame);
      forever begin
         have_exp = (exp_words.size() != 0);
         if (have_exp) begin
            name = exp_names.pop_front();
            exp  = exp_words.pop_front();
         end else begin
            name = "unqueued";
            exp  = '0;
            errors++;
            $display("a frame arrived with no expected word queued");
         end
         for (int b = 0; b < `TX_WORD_W; b++) begin
            if (b != 0) begin
               @(negedge i_clk);
            end
            check_bit({name, " frame"}, b == 0, o_tx_frame);
            check_bit({name, " outclock"}, b < `TX_WORD_W / 2, o_tx_outclock);
            for (int k = 0; k < `TX_LANES; k++) begin
               got[k] = {got[k][`TX_WORD_W-2:0], o_tx_out[k]};
            end
         end
         if (have_exp) begin
            for (int k = 0; k < `TX_LANES; k++) begin
               check_word($sformatf("%s lane%0d", name, k),
                          exp[k * `TX_WORD_W +: `TX_WORD_W], got[k]);
            end
         end
         frames_checked++;
         @(negedge i_clk);
      end
   endtask

   task automatic finish_run();
      $display("errors %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   initial begin
      i_rst_n        = 1'b0;
      i_pll_areset   = 1'b0;
      i_sel          = '0;
      i_par_data     = '0;
      errors         = 0;
      timeouts       = 0;
      cycles         = 0;
      frames_checked = 0;
      lfsr_q         = 16'd43;
      load_table();
      repeat (16) @(posedge i_clk);
      #1;
      check_bit("reset frame", 1'b0, o_tx_frame);
      check_bit("reset outclock", 1'b0, o_tx_outclock);
      check_bit("reset locked", 1'b0, o_tx_locked);
      for (int k = 0; k < `TX_LANES; k++) begin
         check_bit($sformatf("reset out%0d", k), 1'b0, o_tx_out[k]);
      end
      i_rst_n = 1'b1;
      // First frame goes out before any row is applied
      exp_names.push_back("first_frame");
      exp_words.push_back('0);
      for (int r = 0; r < n_rows; r++) begin
         drive_row(r);
      end
      wait (frames_checked == n_rows + 1);
      finish_run();
   end

   initial begin
      collect_frames();
   end

   initial begin
      wait (i_rst_n === 1'b1);
      lock_wait = 0;
      while (o_tx_locked !== 1'b1 && lock_wait < `TX_LOCK_CYCLES + 1) begin
         @(posedge i_clk);
         #1;
         lock_wait++;
      end
      if (o_tx_locked !== 1'b1) begin
         errors++;
         $display("lock did not rise within %0d cycles of reset release",
                  `TX_LOCK_CYCLES + 1);
      end
   end

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      timeouts++;
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
   end

endmodule

`default_nettype wire
